// File: hdl/spi_layer_pkg.sv
// Shared types for the byte-oriented SPI slave layer

package spi_layer_pkg;

   // --------------------
   // Data types
   // --------------------

   // One SPI byte, MSB shifted first
   typedef logic [7:0] byte_t;

   // Bit position inside a byte
   // Counts 0 to 7 and wraps back to 0 at each byte boundary
   typedef logic [2:0] bit_cnt_t;

   // --------------------
   // Prefetch FSM
   // --------------------

   // One-shot transmit prefetch states
   // PF_IDLE     waiting for the start of an SPI byte
   // PF_REQUEST  get_o high, waiting for rdy_i from the bus
   // PF_HOLD     byte stored, request already done for this byte
   typedef enum logic [1:0] {
      PF_IDLE    = 2'd0,
      PF_REQUEST = 2'd1,
      PF_HOLD    = 2'd2
   } prefetch_state_e;

   // Next byte to send when no prefetched byte is available
   localparam byte_t UNDERRUN_BYTE = 8'h00;

endpackage

// File: hdl/byte_fifo_if.sv
`timescale 1ns/1ps

// Write side, read side and status of one byte FIFO
interface byte_fifo_if;
   import spi_layer_pkg::*;

   // Write side, a write while full is dropped
   logic  wr_en;
   byte_t wr_data;
   logic  full;

   // Read side, rd_data always shows the head entry
   // A cycle with rd_en high and empty low removes it
   logic  rd_en;
   byte_t rd_data;
   logic  empty;

   // Producer of entries
   modport writer (
      output wr_en, wr_data,
      input  full
   );

   // Consumer of entries
   modport reader (
      output rd_en,
      input  rd_data, empty
   );

   // The FIFO itself
   modport store (
      input  wr_en, wr_data, rd_en,
      output full, rd_data, empty
   );

endinterface

// File: hdl/byte_fifo.sv
`timescale 1ns/1ps

// Synchronous first-word-fall-through byte FIFO
// Depth is 2**FIFO_DEPTH_LOG2 entries
module byte_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 2
) (
   input  logic       clk_i,
   input  logic       SSEL,
   byte_fifo_if.store fifo
);
   import spi_layer_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   // --------------------
   // Storage and pointers
   // --------------------

   byte_t mem [0:DEPTH-1];

   // Top bit of each pointer tells a full FIFO from an empty one
   logic [FIFO_DEPTH_LOG2:0]   wr_ptr;
   logic [FIFO_DEPTH_LOG2:0]   rd_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] wr_addr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_addr;
   logic                       wr_fire;
   logic                       rd_fire;

   assign wr_addr = wr_ptr[FIFO_DEPTH_LOG2-1:0];
   assign rd_addr = rd_ptr[FIFO_DEPTH_LOG2-1:0];

   // --------------------
   // Status
   // --------------------

   // Same address, different wrap bit means every slot is taken
   assign fifo.full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2])
                       && (wr_addr == rd_addr);
   assign fifo.empty = (wr_ptr == rd_ptr);

   // Writes into a full FIFO and reads from an empty one have no effect
   assign wr_fire = fifo.wr_en & ~fifo.full;
   assign rd_fire = fifo.rd_en & ~fifo.empty;

   // Head entry falls through to the read port
   assign fifo.rd_data = mem[rd_addr];

   // --------------------
   // Sequential logic
   // --------------------

   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         mem[wr_addr] <= fifo.wr_data;
      end
   end

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// File: hdl/spi_shifter.sv
`timescale 1ns/1ps

// Pin side of the SPI slave, mode 0, MSB first
// SCK and MOSI are sampled in the clk_i domain, so SCK must stay
// at least four clk_i cycles in each phase
module spi_shifter #(
   parameter spi_layer_pkg::byte_t HEADER_BYTE = 8'hA7
) (
   input  logic        clk_i,
   input  logic        SSEL,
   input  logic        sck_i,
   input  logic        mosi_i,
   output logic        miso_o,
   output logic        byte_start_o,
   output logic        overflow_o,
   output logic        underrun_o,
   byte_fifo_if.writer rx,
   byte_fifo_if.reader tx
);
   import spi_layer_pkg::*;

   // --------------------
   // Pin synchronizers
   // --------------------

   // Two flops per pin, MOSI kept in step with SCK
   logic sck_meta;
   logic sck_sync;
   logic mosi_meta;
   logic mosi_sync;

   // Previous synchronized SCK level for edge detection
   logic sck_prev;
   logic sck_rise;
   logic sck_fall;

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         sck_meta  <= 1'b0;
         sck_sync  <= 1'b0;
         sck_prev  <= 1'b0;
         mosi_meta <= 1'b0;
         mosi_sync <= 1'b0;
      end else begin
         sck_meta  <= sck_i;
         sck_sync  <= sck_meta;
         sck_prev  <= sck_sync;
         mosi_meta <= mosi_i;
         mosi_sync <= mosi_meta;
      end
   end

   // Edges show up 3 clk_i cycles after the pin changes
   assign sck_rise = sck_sync & ~sck_prev;
   assign sck_fall = ~sck_sync & sck_prev;

   // --------------------
   // Receive path
   // --------------------

   bit_cnt_t   rx_cnt;
   logic [6:0] rx_shift;
   logic       rx_push;

   // Eighth rising edge completes the byte
   assign rx_push = sck_rise & (rx_cnt == 3'd7);

   // First rising edge of every byte starts the bus prefetch
   assign byte_start_o = sck_rise & (rx_cnt == 3'd0);

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         rx_cnt <= '0;
      end else if (sck_rise) begin
         rx_cnt <= rx_cnt + 3'd1;
      end
   end

   // First seven bits, MSB first
   always_ff @(posedge clk_i) begin
      if (sck_rise) begin
         rx_shift <= {rx_shift[5:0], mosi_sync};
      end
   end

   // Last bit goes straight into the FIFO with the other seven
   assign rx.wr_en   = rx_push;
   assign rx.wr_data = {rx_shift, mosi_sync};

   // --------------------
   // Transmit path
   // --------------------

   bit_cnt_t tx_cnt;
   byte_t    tx_shift;
   byte_t    tx_next;
   logic     tx_load;

   // Falling edge after bit 0 moves on to the next byte
   assign tx_load = sck_fall & (tx_cnt == 3'd7);

   // Nothing prefetched in time, send the filler byte instead
   assign tx_next  = tx.empty ? UNDERRUN_BYTE : tx.rd_data;
   assign tx.rd_en = tx_load;

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         tx_cnt   <= '0;
         tx_shift <= HEADER_BYTE;
      end else if (sck_fall) begin
         tx_cnt <= tx_cnt + 3'd1;
         if (tx_load) begin
            tx_shift <= tx_next;
         end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
         end
      end
   end

   // Bit 7 of the header is on the pin before the first SCK edge
   assign miso_o = tx_shift[7];

   // --------------------
   // Sticky error flags
   // --------------------

   // Both flags hold until the slave is deselected
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         overflow_o <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         // Received byte lost, FIFO was full
         if (rx_push && rx.full) begin
            overflow_o <= 1'b1;
         end
         // Byte boundary reached with no prefetched byte
         if (tx_load && tx.empty) begin
            underrun_o <= 1'b1;
         end
      end
   end

endmodule

// File: hdl/bus_prefetch.sv
`timescale 1ns/1ps

// Bus side of the SPI slave layer
// Frames the transaction, prefetches transmit bytes and hands out
// received bytes
module bus_prefetch (
   input  logic                 clk_i,
   input  logic                 SSEL,
   input  logic                 byte_start_i,
   output logic                 cyc_o,
   output logic                 get_o,
   input  logic                 rdy_i,
   input  spi_layer_pkg::byte_t dat_i,
   output logic                 wat_o,
   input  logic                 ack_i,
   output spi_layer_pkg::byte_t dat_o,
   byte_fifo_if.writer          tx,
   byte_fifo_if.reader          rx
);
   import spi_layer_pkg::*;

   // --------------------
   // Framing
   // --------------------

   // High from the first clk_i edge after select until deselect
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         cyc_o <= 1'b0;
      end else begin
         cyc_o <= 1'b1;
      end
   end

   // --------------------
   // Transmit prefetch
   // --------------------

   prefetch_state_e state_q;
   prefetch_state_e state_d;

   // One request per SPI byte
   // A byte_start during PF_REQUEST is absorbed by the pending request
   always_comb begin
      state_d = state_q;
      case (state_q)
         PF_IDLE: begin
            if (byte_start_i) begin
               state_d = PF_REQUEST;
            end
         end
         PF_REQUEST: begin
            if (rdy_i) begin
               state_d = PF_HOLD;
            end
         end
         PF_HOLD: begin
            // Back-to-back byte start re-arms without passing idle
            state_d = byte_start_i ? PF_REQUEST : PF_IDLE;
         end
         default: begin
            state_d = PF_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         state_q <= PF_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // get_o drops the cycle after rdy_i
   assign get_o = (state_q == PF_REQUEST);

   // Bus byte goes straight into the transmit FIFO
   assign tx.wr_en   = get_o & rdy_i;
   assign tx.wr_data = dat_i;

   // --------------------
   // Receive read path
   // --------------------

   assign rx.rd_en = ack_i;
   assign wat_o    = rx.empty;
   assign dat_o    = rx.rd_data;

endmodule

// File: hdl/spi_layer.sv
`timescale 1ns/1ps

// Byte-oriented SPI slave layer, mode 0, MSB first
// SSEL high deselects the slave and resets the whole layer
module spi_layer #(
   parameter spi_layer_pkg::byte_t HEADER_BYTE     = 8'hA7,
   parameter int                   FIFO_DEPTH_LOG2 = 2
) (
   input  logic                 clk_i,
   input  logic                 SSEL,

   // SPI pins
   input  logic                 sck_i,
   input  logic                 mosi_i,
   output logic                 miso_o,

   // Bus master strobes
   output logic                 cyc_o,
   output logic                 get_o,
   input  logic                 rdy_i,
   input  spi_layer_pkg::byte_t dat_i,
   output logic                 wat_o,
   input  logic                 ack_i,
   output spi_layer_pkg::byte_t dat_o,

   // Sticky diagnostics
   output logic                 overflow_o,
   output logic                 underrun_o
);

   // One-cycle pulse at the first SCK rise of each byte
   logic byte_start;

   // Bus side fills tx_fifo, pin side fills rx_fifo
   byte_fifo_if tx_fifo ();
   byte_fifo_if rx_fifo ();

   // --------------------
   // Pin side
   // --------------------

   spi_shifter #(
      .HEADER_BYTE (HEADER_BYTE)
   ) spi_shifter_i (
      .clk_i        (clk_i),
      .SSEL         (SSEL),
      .sck_i        (sck_i),
      .mosi_i       (mosi_i),
      .miso_o       (miso_o),
      .byte_start_o (byte_start),
      .overflow_o   (overflow_o),
      .underrun_o   (underrun_o),
      .rx           (rx_fifo),
      .tx           (tx_fifo)
   );

   // --------------------
   // FIFOs
   // --------------------

   byte_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) tx_fifo_i (
      .clk_i (clk_i),
      .SSEL  (SSEL),
      .fifo  (tx_fifo)
   );

   byte_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) rx_fifo_i (
      .clk_i (clk_i),
      .SSEL  (SSEL),
      .fifo  (rx_fifo)
   );

   // --------------------
   // Bus side
   // --------------------

   bus_prefetch bus_prefetch_i (
      .clk_i        (clk_i),
      .SSEL         (SSEL),
      .byte_start_i (byte_start),
      .cyc_o        (cyc_o),
      .get_o        (get_o),
      .rdy_i        (rdy_i),
      .dat_i        (dat_i),
      .wat_o        (wat_o),
      .ack_i        (ack_i),
      .dat_o        (dat_o),
      .tx           (tx_fifo),
      .rx           (rx_fifo)
   );

endmodule

// File: test/spi_layer_tb.sv
`timescale 1ns/1ps

module spi_layer_tb;
   import spi_layer_pkg::*;

   localparam byte_t HEADER      = 8'hA7;
   localparam int    DEPTH       = 4;
   localparam int    HALF_SCK    = 6;
   localparam int    BYTE_CYCLES = 16 * HALF_SCK;
   localparam int    MAX_CASES   = 16;

   // DUT inputs start in the deselected state
   logic  clk_i  = 1'b0;
   logic  SSEL   = 1'b1;
   logic  sck_i  = 1'b0;
   logic  mosi_i = 1'b0;
   logic  rdy_i  = 1'b0;
   byte_t dat_i  = '0;
   logic  ack_i  = 1'b0;
   logic  miso_o;
   logic  cyc_o;
   logic  get_o;
   logic  wat_o;
   logic  overflow_o;
   logic  underrun_o;
   byte_t dat_o;

   // Case table with six byte slots per line
   int      num_cases = 0;
   int      cnt_a    [0:MAX_CASES-1];
   int      maxd_a   [0:MAX_CASES-1];
   int      ack_a    [0:MAX_CASES-1];
   byte_t   mosi_a   [0:MAX_CASES*6-1];
   byte_t   supply_a [0:MAX_CASES*6-1];
   byte_t   miso_rx  [0:5];
   int      value_errors    = 0;
   int      protocol_errors = 0;
   int      gets;
   int      reads;
   logic    active = 1'b0;
   integer  seed = 42657;
   realtime limit_ns = 0.0;

   spi_layer #(.HEADER_BYTE(HEADER), .FIFO_DEPTH_LOG2(2)) spi_layer_i (.*);

   always #4 clk_i = ~clk_i;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   // --------------------
   // Cases file
   // --------------------

   task automatic read_cases();
      int    fd;
      int    rc;
      int    b;
      string line;
      fd = $fopen("test/spi_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the cases file test/spi_cases.txt");
         protocol_errors++;
         return;
      end
      while ($fgets(line, fd) > 0 && num_cases < MAX_CASES) begin
         // Skip column notes and blank lines
         if (line.len() > 2 && line[0] != "#") begin
            b = num_cases * 6;
            rc = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %d %d",
                         cnt_a[num_cases], mosi_a[b], mosi_a[b+1], mosi_a[b+2],
                         mosi_a[b+3], mosi_a[b+4], mosi_a[b+5], supply_a[b],
                         supply_a[b+1], supply_a[b+2], supply_a[b+3],
                         supply_a[b+4], supply_a[b+5], maxd_a[num_cases],
                         ack_a[num_cases]);
            if (rc == 15) begin
               num_cases++;
            end else begin
               $display("A line of the cases file could not be parsed: %s", line);
               protocol_errors++;
            end
         end
      end
      $fclose(fd);
   endtask

   // --------------------
   // Bus and SPI models
   // --------------------

   task automatic check_idle();
      check_value("cyc_o", cyc_o, 1'b0);
      check_value("get_o", get_o, 1'b0);
      check_value("overflow_o", overflow_o, 1'b0);
      check_value("underrun_o", underrun_o, 1'b0);
      check_value("wat_o", wat_o, 1'b1);
      check_value("miso_o", miso_o, HEADER[7]);
   endtask

   // Mode 0 master that sets MOSI while SCK is low and takes MISO just before the rise
   task automatic spi_master(input int c);
      byte_t tx;
      byte_t rx;
      for (int i = 0; i < cnt_a[c]; i++) begin
         tx = mosi_a[c*6 + i];
         for (int k = 7; k >= 0; k--) begin
            mosi_i = tx[k];
            repeat (HALF_SCK) @(negedge clk_i);
            rx = {rx[6:0], miso_o};
            check_value("cyc_o", cyc_o, 1'b1);
            sck_i = 1'b1;
            repeat (HALF_SCK) @(negedge clk_i);
            sck_i = 1'b0;
         end
         miso_rx[i] = rx;
      end
      // Let the last push and transmit load settle
      repeat (2 * HALF_SCK) @(negedge clk_i);
   endtask

   // Answers each get_o after a random delay between max/2 and max
   task automatic bus_responder(input int c);
      int delay;
      while (active) begin
         @(negedge clk_i);
         if (get_o === 1'b1) begin
            delay = maxd_a[c] / 2
                    + ($random(seed) & 32'h7fff_ffff) % (maxd_a[c] - maxd_a[c] / 2 + 1);
            repeat (delay) begin
               if (active) @(negedge clk_i);
            end
            dat_i = (gets < 6) ? supply_a[c*6 + gets] : 8'h00;
            gets++;
            rdy_i = 1'b1;
            @(negedge clk_i);
            rdy_i = 1'b0;
            if (get_o !== 1'b0) begin
               $display("get_o did not fall in the cycle after rdy_i");
               protocol_errors++;
            end
         end
      end
   endtask

   // Consumes every waiting byte when acks are enabled
   task automatic bus_reader(input int c);
      while (active) begin
         @(negedge clk_i);
         ack_i = 1'b0;
         if (ack_a[c] != 0 && wat_o === 1'b0) begin
            if (reads < cnt_a[c]) begin
               check_value("dat_o", dat_o, mosi_a[c*6 + reads]);
            end else begin
               $display("More bytes were received than were sent");
               protocol_errors++;
            end
            reads++;
            ack_i = 1'b1;
         end
      end
      ack_i = 1'b0;
   endtask

   // --------------------
   // One transaction
   // --------------------

   task automatic run_case(input int c);
      bit long_wait;
      // Bus answer arrives only after the first transmit load
      long_wait = (maxd_a[c] / 2 > BYTE_CYCLES);
      SSEL = 1'b1;
      repeat (8) @(negedge clk_i);
      check_idle();
      SSEL   = 1'b0;
      gets   = 0;
      reads  = 0;
      active = 1'b1;
      repeat (2) @(negedge clk_i);
      fork
         begin
            spi_master(c);
            active = 1'b0;
         end
         bus_responder(c);
         bus_reader(c);
      join
      check_value("miso_o header", miso_rx[0], HEADER);
      for (int k = 1; k < cnt_a[c]; k++) begin
         if (!long_wait) check_value("miso_o byte", miso_rx[k], supply_a[c*6 + k - 1]);
      end
      if (long_wait && cnt_a[c] > 1) check_value("miso_o byte", miso_rx[1], 8'h00);
      if (!long_wait) check_value("get_o count", gets, cnt_a[c]);
      if (ack_a[c] != 0) check_value("dat_o count", reads, cnt_a[c]);
      check_value("overflow_o", overflow_o, ack_a[c] == 0 && cnt_a[c] > DEPTH);
      check_value("underrun_o", underrun_o, long_wait);
   endtask

   initial begin
      realtime total_ns;
      total_ns = 0.0;
      read_cases();
      for (int c = 0; c < num_cases; c++) begin
         total_ns += (cnt_a[c] * BYTE_CYCLES + 200) * 8.0;
      end
      // Watchdog starts only once the whole sum is known
      limit_ns = total_ns;
      for (int c = 0; c < num_cases; c++) begin
         run_case(c);
      end
      SSEL = 1'b1;
      repeat (8) @(negedge clk_i);
      check_idle();
      $display("Cases %0d, value errors %0d, protocol errors %0d",
               num_cases, value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0 && num_cases > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog sized from the case table
   initial begin
      wait (limit_ns > 0.0);
      #(limit_ns);
      $display("Timeout, the transactions did not finish in %0t", $time);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: sources.f
hdl/spi_layer_pkg.sv
hdl/byte_fifo_if.sv
hdl/byte_fifo.sv
hdl/spi_shifter.sv
hdl/bus_prefetch.sv
hdl/spi_layer.sv
test/spi_layer_tb.sv

// File: test/spi_cases.txt
# count, MOSI bytes 1-6, bytes supplied on dat_i 1-6 (hex, unused slots 00)
# max rdy_i delay in cycles, ack flag (0 means received bytes are never read)
1 3c 00 00 00 00 00  11 00 00 00 00 00  4 1
2 a5 5a 00 00 00 00  c3 e1 00 00 00 00  8 1
4 01 02 04 08 00 00  f0 0f 99 66 00 00  12 1
6 de ad be ef 12 34  55 aa 5a a5 3c c3  40 1
6 80 40 20 10 08 04  fe fd fb f7 ef df  0 1
3 77 88 99 00 00 00  ab cd ef 00 00 00  200 1
6 11 22 33 44 55 66  91 92 93 94 95 96  20 0
5 c0 ff ee 00 42 00  71 72 73 74 75 00  16 1
4 e7 7e 18 81 00 00  0a 0b 0c 0d 00 00  10 0
6 6c 6d 6e 6f 70 71  b1 b2 b3 b4 b5 b6  240 0
3 f1 f2 f3 00 00 00  d1 d2 d3 00 00 00  30 1
